/* project.f */
rtl/cpri_buf_pkg.sv
rtl/frame_ring_ram.sv
rtl/cpri_rxdata_buffer.sv
rtl/cpri_buf_csr.sv
rtl/cpri_rx_top.sv
tests/tb_cpri_rx_top.sv

/* tests/tb_cpri_rx_top.sv */
`timescale 1ns/1ns
//--------------------------------------------------
// Testbench for the CPRI receive top level
// Reference model, output monitor and AXI4-Lite access
//--------------------------------------------------
module tb_cpri_rx_top;
    import cpri_buf_pkg::*;

    localparam int SEED       = 32'h5f70;
    localparam int WAIT_LIMIT = 5000;

    logic                  clk;
    logic                  reset;
    data_word_t            rx_data;
    logic                  rx_valid;
    logic                  tx_ready;
    data_word_t            tx_data;
    chip_seq_t             tx_addr;
    logic                  tx_last;
    logic                  tx_valid;
    logic                  axil_awvalid;
    logic                  axil_awready;
    logic [AXI_ADDR_W-1:0] axil_awaddr;
    logic                  axil_wvalid;
    logic                  axil_wready;
    logic [AXI_DATA_W-1:0] axil_wdata;
    logic [3:0]            axil_wstrb;
    logic                  axil_bvalid;
    logic                  axil_bready;
    logic [1:0]            axil_bresp;
    logic                  axil_arvalid;
    logic                  axil_arready;
    logic [AXI_ADDR_W-1:0] axil_araddr;
    logic                  axil_rvalid;
    logic                  axil_rready;
    logic [AXI_DATA_W-1:0] axil_rdata;
    logic [1:0]            axil_rresp;

    // Reference model state
    int         data_seed;
    int         ready_seed;
    int         errors;
    bit         throttle_on;
    bit         model_enable;
    int         model_fill;
    int         exp_in;
    int         exp_out;
    int         exp_drop;
    int         out_pos;
    data_word_t exp_q[$];

    cpri_rx_top uut (
        .i_clk            (clk),
        .i_reset          (reset),
        .i_rx_data        (rx_data),
        .i_rvalid         (rx_valid),
        .i_rready         (tx_ready),
        .o_tx_data        (tx_data),
        .o_tx_addr        (tx_addr),
        .o_tx_last        (tx_last),
        .o_tvalid         (tx_valid),
        .i_s_axil_awvalid (axil_awvalid),
        .o_s_axil_awready (axil_awready),
        .i_s_axil_awaddr  (axil_awaddr),
        .i_s_axil_wvalid  (axil_wvalid),
        .o_s_axil_wready  (axil_wready),
        .i_s_axil_wdata   (axil_wdata),
        .i_s_axil_wstrb   (axil_wstrb),
        .o_s_axil_bvalid  (axil_bvalid),
        .i_s_axil_bready  (axil_bready),
        .o_s_axil_bresp   (axil_bresp),
        .i_s_axil_arvalid (axil_arvalid),
        .o_s_axil_arready (axil_arready),
        .i_s_axil_araddr  (axil_araddr),
        .o_s_axil_rvalid  (axil_rvalid),
        .i_s_axil_rready  (axil_rready),
        .o_s_axil_rdata   (axil_rdata),
        .o_s_axil_rresp   (axil_rresp)
    );

    always #2 clk = ~clk;

    //--------------------------------------------------
    // Reference functions
    //--------------------------------------------------
    // Frame is kept when enabled and a slot is free at its start
    function automatic bit frame_accepted(input bit enable, input int fill);
        return enable && (fill < NUM_SLOTS);
    endfunction

    // Expected {last, sequence} for a word position inside its frame
    function automatic logic [7:0] expected_tag(input int pos);
        int seq;
        seq = pos % CHIP_WORDS;
        return {seq == CHIP_WORDS - 1, 7'(seq)};
    endfunction

    //--------------------------------------------------
    // Output monitor
    //--------------------------------------------------
    always @(negedge clk) begin
        data_word_t exp_word;
        logic [7:0] tag;
        if (!reset) begin
            if (tx_last && !tx_valid) begin
                errors++;
                $display("Error at %0t: last flag without valid", $time);
            end
            if (tx_valid && exp_q.size() == 0) begin
                errors++;
                $display("Error at %0t: unexpected output word %h", $time, tx_data);
            end else if (tx_valid) begin
                exp_word = exp_q.pop_front();
                tag = expected_tag(out_pos);
                if (tx_data !== exp_word) begin
                    errors++;
                    $display("Error at %0t: data at position %0d is %h, expected %h",
                             $time, out_pos, tx_data, exp_word);
                end
                if (tx_addr !== tag[6:0]) begin
                    errors++;
                    $display("Error at %0t: sequence at position %0d is %0d, expected %0d",
                             $time, out_pos, tx_addr, tag[6:0]);
                end
                if (tx_last !== tag[7]) begin
                    errors++;
                    $display("Error at %0t: last flag at position %0d is %b, expected %b",
                             $time, out_pos, tx_last, tag[7]);
                end
                // Frame fully delivered frees its slot in the model
                if (out_pos == FRAME_WORDS - 1) begin
                    out_pos = 0;
                    model_fill--;
                    exp_out++;
                end else begin
                    out_pos++;
                end
            end
        end
    end

    // Random read enable while throttling
    always @(negedge clk) begin
        if (throttle_on) begin
            tx_ready = ($random(ready_seed) & 3) != 0;
        end
    end

    //--------------------------------------------------
    // Run control and AXI4-Lite access
    //--------------------------------------------------
    task automatic report_and_finish();
        $display("Closing report: %0d errors", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        errors++;
        $display("Timeout while waiting for %s", what);
        report_and_finish();
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
        int count;
        @(negedge clk);
        axil_awaddr  = addr;
        axil_wdata   = data;
        axil_wstrb   = 4'hF;
        axil_awvalid = 1'b1;
        axil_wvalid  = 1'b1;
        axil_bready  = 1'b1;
        // Ready is seen at the edge that takes address and data
        count = 0;
        @(posedge clk);
        while (!(axil_awready || axil_wready)) begin
            if (count == WAIT_LIMIT) give_up("write address and data ready");
            @(posedge clk);
            count++;
        end
        if (axil_awready !== 1'b1 || axil_wready !== 1'b1) begin
            errors++;
            $display("Error at %0t: write ready %b%b, expected both high at %h",
                     $time, axil_awready, axil_wready, addr);
        end
        @(negedge clk);
        axil_awvalid = 1'b0;
        axil_wvalid  = 1'b0;
        count = 0;
        while (!axil_bvalid) begin
            if (count == WAIT_LIMIT) give_up("write response");
            @(negedge clk);
            count++;
        end
        if (axil_bresp !== AXI_RESP_OKAY) begin
            errors++;
            $display("Error at %0t: write response %b at %h", $time, axil_bresp, addr);
        end
        @(negedge clk);
        axil_bready = 1'b0;
        if (addr == REG_CTRL) begin
            model_enable = data[0];
        end
    endtask

    task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data);
        int count;
        @(negedge clk);
        axil_araddr  = addr;
        axil_arvalid = 1'b1;
        axil_rready  = 1'b1;
        count = 0;
        @(posedge clk);
        while (!axil_arready) begin
            if (count == WAIT_LIMIT) give_up("read address ready");
            @(posedge clk);
            count++;
        end
        @(negedge clk);
        axil_arvalid = 1'b0;
        count = 0;
        while (!axil_rvalid) begin
            if (count == WAIT_LIMIT) give_up("read data");
            @(negedge clk);
            count++;
        end
        data = axil_rdata;
        if (axil_rresp !== AXI_RESP_OKAY) begin
            errors++;
            $display("Error at %0t: read response %b at %h", $time, axil_rresp, addr);
        end
        @(negedge clk);
        axil_rready = 1'b0;
    endtask

    task automatic check_reg(input logic [AXI_ADDR_W-1:0] addr, input int expected);
        logic [31:0] value;
        axil_read(addr, value);
        if (value !== 32'(expected)) begin
            errors++;
            $display("Error at %0t: register %h reads %0d, expected %0d",
                     $time, addr, value, expected);
        end
    endtask

    task automatic check_counters();
        check_reg(REG_FRAMES_IN, exp_in);
        check_reg(REG_FRAMES_OUT, exp_out);
        check_reg(REG_DROPPED, exp_drop);
    endtask

    //--------------------------------------------------
    // Frame stimulus
    //--------------------------------------------------
    task automatic send_frame(input bit pace);
        bit accept;
        int count;
        count = 0;
        // Optionally hold the source until the model has a free slot
        while (pace && model_fill >= NUM_SLOTS) begin
            if (count == WAIT_LIMIT) give_up("a free frame slot");
            @(negedge clk);
            rx_valid = 1'b0;
            count++;
        end
        accept = frame_accepted(model_enable, model_fill);
        if (accept) begin
            exp_in++;
        end else if (model_enable) begin
            exp_drop += FRAME_WORDS;
        end
        for (int i = 0; i < FRAME_WORDS; i++) begin
            @(negedge clk);
            rx_data  = {$random(data_seed), $random(data_seed)};
            rx_valid = 1'b1;
            if (accept) begin
                exp_q.push_back(rx_data);
            end
        end
        if (accept) begin
            model_fill++;
        end
    endtask

    task automatic end_input();
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int count;
        count = 0;
        while (exp_q.size() != 0) begin
            if (count == WAIT_LIMIT) give_up("all expected words at the output");
            @(negedge clk);
            count++;
        end
        idle(4);
    endtask

    //--------------------------------------------------
    // Test sequence
    //--------------------------------------------------
    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        rx_data      = '0;
        rx_valid     = 1'b0;
        tx_ready     = 1'b0;
        axil_awvalid = 1'b0;
        axil_awaddr  = '0;
        axil_wvalid  = 1'b0;
        axil_wdata   = '0;
        axil_wstrb   = '0;
        axil_bready  = 1'b0;
        axil_arvalid = 1'b0;
        axil_araddr  = '0;
        axil_rready  = 1'b0;
        data_seed    = SEED;
        ready_seed   = SEED;
        errors       = 0;
        throttle_on  = 1'b0;
        model_enable = 1'b0;
        model_fill   = 0;
        exp_in       = 0;
        exp_out      = 0;
        exp_drop     = 0;
        out_pos      = 0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        // Reset state and control bit
        if (tx_valid !== 1'b0) begin
            errors++;
            $display("Error at %0t: output valid high after reset", $time);
        end
        check_reg(REG_CTRL, 0);
        check_reg(REG_STATUS, 0);
        check_counters();
        axil_write(REG_CTRL, 1);
        check_reg(REG_CTRL, 1);

        // Four frames with the output always enabled
        tx_ready = 1'b1;
        repeat (4) send_frame(1'b1);
        end_input();
        wait_drain();
        check_counters();

        // Throttled read enable over three frames
        throttle_on = 1'b1;
        repeat (3) send_frame(1'b1);
        end_input();
        wait_drain();
        throttle_on = 1'b0;
        @(negedge clk);
        tx_ready = 1'b0;

        // Overflow with reads held off drops the third frame
        repeat (3) send_frame(1'b0);
        end_input();
        idle(4);
        check_reg(REG_STATUS, NUM_SLOTS);
        check_counters();
        tx_ready = 1'b1;
        wait_drain();
        check_reg(REG_STATUS, 0);
        check_counters();

        // Disabled input is neither accepted nor counted
        axil_write(REG_CTRL, 0);
        check_reg(REG_CTRL, 0);
        send_frame(1'b1);
        end_input();
        idle(FRAME_WORDS / 2);
        check_reg(REG_STATUS, 0);
        check_counters();

        report_and_finish();
    end

endmodule

/* rtl/cpri_rx_top.sv */
`timescale 1ns/1ns
//--------------------------------------------------
// CPRI receive top level
// Data buffer with its AXI4-Lite register block
//--------------------------------------------------
module cpri_rx_top (
    input  logic                                    i_clk,
    input  logic                                    i_reset,
    input  cpri_buf_pkg::data_word_t                i_rx_data,
    input  logic                                    i_rvalid,
    input  logic                                    i_rready,
    output cpri_buf_pkg::data_word_t                o_tx_data,
    output cpri_buf_pkg::chip_seq_t                 o_tx_addr,
    output logic                                    o_tx_last,
    output logic                                    o_tvalid,
    input  logic                                    i_s_axil_awvalid,
    output logic                                    o_s_axil_awready,
    input  logic [cpri_buf_pkg::AXI_ADDR_W-1:0]     i_s_axil_awaddr,
    input  logic                                    i_s_axil_wvalid,
    output logic                                    o_s_axil_wready,
    input  logic [cpri_buf_pkg::AXI_DATA_W-1:0]     i_s_axil_wdata,
    input  logic [cpri_buf_pkg::AXI_DATA_W/8-1:0]   i_s_axil_wstrb,
    output logic                                    o_s_axil_bvalid,
    input  logic                                    i_s_axil_bready,
    output logic [1:0]                              o_s_axil_bresp,
    input  logic                                    i_s_axil_arvalid,
    output logic                                    o_s_axil_arready,
    input  logic [cpri_buf_pkg::AXI_ADDR_W-1:0]     i_s_axil_araddr,
    output logic                                    o_s_axil_rvalid,
    input  logic                                    i_s_axil_rready,
    output logic [cpri_buf_pkg::AXI_DATA_W-1:0]     o_s_axil_rdata,
    output logic [1:0]                              o_s_axil_rresp
);
    import cpri_buf_pkg::*;

    logic      enable;
    logic      frame_in;
    logic      frame_out;
    logic      word_drop;
    slot_cnt_t fill;

    cpri_rxdata_buffer u_buffer (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rx_data   (i_rx_data),
        .i_rvalid    (i_rvalid),
        .i_rready    (i_rready),
        .i_enable    (enable),
        .o_tx_data   (o_tx_data),
        .o_tx_addr   (o_tx_addr),
        .o_tx_last   (o_tx_last),
        .o_tvalid    (o_tvalid),
        .o_frame_in  (frame_in),
        .o_frame_out (frame_out),
        .o_word_drop (word_drop),
        .o_fill      (fill)
    );

    cpri_buf_csr u_csr (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_frame_in   (frame_in),
        .i_frame_out  (frame_out),
        .i_word_drop  (word_drop),
        .i_fill       (fill),
        .o_enable     (enable),
        .i_awvalid    (i_s_axil_awvalid),
        .o_awready    (o_s_axil_awready),
        .i_awaddr     (i_s_axil_awaddr),
        .i_wvalid     (i_s_axil_wvalid),
        .o_wready     (o_s_axil_wready),
        .i_wdata      (i_s_axil_wdata),
        .i_wstrb      (i_s_axil_wstrb),
        .o_bvalid     (o_s_axil_bvalid),
        .i_bready     (i_s_axil_bready),
        .o_bresp      (o_s_axil_bresp),
        .i_arvalid    (i_s_axil_arvalid),
        .o_arready    (o_s_axil_arready),
        .i_araddr     (i_s_axil_araddr),
        .o_rvalid     (o_s_axil_rvalid),
        .i_rready_axi (i_s_axil_rready),
        .o_rdata      (o_s_axil_rdata),
        .o_rresp      (o_s_axil_rresp)
    );

endmodule

/* rtl/cpri_buf_csr.sv */
`timescale 1ns/1ns
//--------------------------------------------------
// CPRI buffer register block
// AXI4-Lite slave with enable, event counters, fill
//--------------------------------------------------
module cpri_buf_csr (
    input  logic                                    i_clk,
    input  logic                                    i_reset,
    input  logic                                    i_frame_in,
    input  logic                                    i_frame_out,
    input  logic                                    i_word_drop,
    input  cpri_buf_pkg::slot_cnt_t                 i_fill,
    output logic                                    o_enable,
    input  logic                                    i_awvalid,
    output logic                                    o_awready,
    input  logic [cpri_buf_pkg::AXI_ADDR_W-1:0]     i_awaddr,
    input  logic                                    i_wvalid,
    output logic                                    o_wready,
    input  logic [cpri_buf_pkg::AXI_DATA_W-1:0]     i_wdata,
    input  logic [cpri_buf_pkg::AXI_DATA_W/8-1:0]   i_wstrb,
    output logic                                    o_bvalid,
    input  logic                                    i_bready,
    output logic [1:0]                              o_bresp,
    input  logic                                    i_arvalid,
    output logic                                    o_arready,
    input  logic [cpri_buf_pkg::AXI_ADDR_W-1:0]     i_araddr,
    output logic                                    o_rvalid,
    input  logic                                    i_rready_axi,
    output logic [cpri_buf_pkg::AXI_DATA_W-1:0]     o_rdata,
    output logic [1:0]                              o_rresp
);
    import cpri_buf_pkg::*;

    csr_state_t            state;
    logic                  wr_accept;
    logic                  rd_accept;
    logic [AXI_DATA_W-1:0] frames_in_cnt;
    logic [AXI_DATA_W-1:0] frames_out_cnt;
    logic [AXI_DATA_W-1:0] dropped_cnt;
    logic [AXI_DATA_W-1:0] rd_mux;

    // Counters stop at all ones
    function automatic logic [AXI_DATA_W-1:0] sat_inc(
        input logic [AXI_DATA_W-1:0] value,
        input logic                  hit
    );
        if (hit && value != '1) begin
            return value + 1'b1;
        end
        return value;
    endfunction

    //--------------------------------------------------
    // Channel handshake
    //--------------------------------------------------
    // Write wins when both arrive together
    assign wr_accept = (state == CSR_IDLE) & i_awvalid & i_wvalid;
    assign rd_accept = (state == CSR_IDLE) & i_arvalid & ~wr_accept;

    assign o_awready = wr_accept;
    assign o_wready  = wr_accept;
    assign o_arready = rd_accept;
    assign o_bvalid  = (state == CSR_WRESP);
    assign o_rvalid  = (state == CSR_RRESP);
    assign o_bresp   = AXI_RESP_OKAY;
    assign o_rresp   = AXI_RESP_OKAY;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= CSR_IDLE;
        end else begin
            case (state)
                CSR_IDLE: begin
                    if (wr_accept) begin
                        state <= CSR_WRESP;
                    end else if (rd_accept) begin
                        state <= CSR_RRESP;
                    end
                end
                CSR_WRESP: begin
                    if (i_bready) begin
                        state <= CSR_IDLE;
                    end
                end
                CSR_RRESP: begin
                    if (i_rready_axi) begin
                        state <= CSR_IDLE;
                    end
                end
                default: state <= CSR_IDLE;
            endcase
        end
    end

    //--------------------------------------------------
    // Control bit and event counters
    //--------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_enable       <= 1'b0;
            frames_in_cnt  <= '0;
            frames_out_cnt <= '0;
            dropped_cnt    <= '0;
        end else begin
            if (wr_accept && i_awaddr == REG_CTRL && i_wstrb[0]) begin
                o_enable <= i_wdata[0];
            end
            frames_in_cnt  <= sat_inc(frames_in_cnt, i_frame_in);
            frames_out_cnt <= sat_inc(frames_out_cnt, i_frame_out);
            dropped_cnt    <= sat_inc(dropped_cnt, i_word_drop);
        end
    end

    // Unmapped addresses read as zero
    always_comb begin
        case (i_araddr)
            REG_CTRL:       rd_mux = AXI_DATA_W'(o_enable);
            REG_FRAMES_IN:  rd_mux = frames_in_cnt;
            REG_FRAMES_OUT: rd_mux = frames_out_cnt;
            REG_DROPPED:    rd_mux = dropped_cnt;
            REG_STATUS:     rd_mux = AXI_DATA_W'(i_fill);
            default:        rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (rd_accept) begin
            o_rdata <= rd_mux;
        end
    end

    a_one_response: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_bvalid && o_rvalid))
        else $error("write and read responses overlap");

endmodule

/* rtl/cpri_rxdata_buffer.sv */
`timescale 1ns/1ns
//--------------------------------------------------
// CPRI receive data buffer
// Frames input words into the ring memory and reads
// them back tagged with chip sequence numbers
//--------------------------------------------------
module cpri_rxdata_buffer (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  cpri_buf_pkg::data_word_t  i_rx_data,
    input  logic                      i_rvalid,
    input  logic                      i_rready,
    input  logic                      i_enable,
    output cpri_buf_pkg::data_word_t  o_tx_data,
    output cpri_buf_pkg::chip_seq_t   o_tx_addr,
    output logic                      o_tx_last,
    output logic                      o_tvalid,
    output logic                      o_frame_in,
    output logic                      o_frame_out,
    output logic                      o_word_drop,
    output cpri_buf_pkg::slot_cnt_t   o_fill
);
    import cpri_buf_pkg::*;

    // Write side
    frame_addr_t wr_cnt;
    logic        wr_frame_start;
    logic        frame_keep;
    logic        frame_full;
    logic        keep_now;
    logic        full_now;
    logic        slot_free;
    slot_cnt_t   fill;
    slot_cnt_t   fill_next;
    logic        wr_en_q;
    frame_addr_t wr_addr_q;
    data_word_t  wr_data_q;
    logic        wr_end_q;
    logic        wr_commit;

    // Read side
    frame_addr_t                 rd_cnt;
    logic                        rd_en;
    logic                        rd_end;
    logic                        rd_retire;
    logic                        frame_ready;
    data_word_t                  rd_data;
    logic                        rd_valid;
    logic [RAM_READ_LATENCY-1:0] start_pipe;
    logic                        rd_start;
    chip_seq_t                   seq_now;

    //--------------------------------------------------
    // Write framing and drop decision
    //--------------------------------------------------
    assign wr_commit = wr_en_q & wr_end_q;

    // Include the commit and release landing on this same edge
    assign fill_next = fill + slot_cnt_t'(wr_commit) - slot_cnt_t'(rd_retire);
    assign slot_free = (fill_next < slot_cnt_t'(NUM_SLOTS));

    assign wr_frame_start = (wr_cnt == '0);
    assign keep_now = wr_frame_start ? (i_enable & slot_free) : frame_keep;
    assign full_now = wr_frame_start ? (i_enable & ~slot_free) : frame_full;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_cnt      <= '0;
            frame_keep  <= 1'b0;
            frame_full  <= 1'b0;
            wr_en_q     <= 1'b0;
            wr_end_q    <= 1'b0;
            o_word_drop <= 1'b0;
        end else begin
            wr_en_q     <= i_rvalid & keep_now;
            wr_end_q    <= i_rvalid & (wr_cnt == frame_addr_t'(FRAME_WORDS - 1));
            o_word_drop <= i_rvalid & full_now;
            if (i_rvalid) begin
                // Decision holds for the whole frame
                if (wr_frame_start) begin
                    frame_keep <= i_enable & slot_free;
                    frame_full <= i_enable & ~slot_free;
                end
                if (wr_cnt == frame_addr_t'(FRAME_WORDS - 1)) begin
                    wr_cnt <= '0;
                end else begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        wr_addr_q <= wr_cnt;
        wr_data_q <= i_rx_data;
    end

    //--------------------------------------------------
    // Read addressing
    //--------------------------------------------------
    assign rd_en     = i_rready & frame_ready;
    assign rd_end    = (rd_cnt == frame_addr_t'(FRAME_WORDS - 1));
    assign rd_retire = rd_en & rd_end;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rd_cnt      <= '0;
            start_pipe  <= '0;
            o_frame_out <= 1'b0;
        end else begin
            o_frame_out <= rd_retire;
            // Frame start tag travels beside the memory pipeline
            start_pipe  <= (start_pipe << 1) | RAM_READ_LATENCY'(rd_en && rd_cnt == '0);
            if (rd_en) begin
                rd_cnt <= rd_end ? '0 : rd_cnt + 1'b1;
            end
        end
    end

    frame_ring_ram u_ram (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_wr_en        (wr_en_q),
        .i_wr_addr      (wr_addr_q),
        .i_wr_data      (wr_data_q),
        .i_wr_frame_end (wr_end_q),
        .i_rd_en        (rd_en),
        .i_rd_addr      (rd_cnt),
        .i_rd_frame_end (rd_end),
        .o_rd_data      (rd_data),
        .o_rd_valid     (rd_valid),
        .o_frame_ready  (frame_ready),
        .o_fill         (fill)
    );

    //--------------------------------------------------
    // Chip sequence tagging and output register
    //--------------------------------------------------
    assign rd_start = start_pipe[RAM_READ_LATENCY-1];
    assign seq_now  = (rd_start || o_tx_addr == chip_seq_t'(CHIP_WORDS - 1)) ?
                      '0 : o_tx_addr + 1'b1;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_tvalid  <= 1'b0;
            o_tx_last <= 1'b0;
            o_tx_addr <= '0;
        end else begin
            o_tvalid  <= rd_valid;
            o_tx_last <= rd_valid & (seq_now == chip_seq_t'(CHIP_WORDS - 1));
            if (rd_valid) begin
                o_tx_addr <= seq_now;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        o_tx_data <= rd_data;
    end

    assign o_frame_in = wr_commit;
    assign o_fill     = fill;

    // A chip group closes on valid data and the next valid word restarts at zero
    a_last_with_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        o_tx_last |-> o_tvalid ##1 (!o_tvalid || o_tx_addr == '0))
        else $error("chip last flag without valid or bad wrap");

endmodule

/* rtl/frame_ring_ram.sv */
`timescale 1ns/1ns
//--------------------------------------------------
// Two-slot frame memory
// Slot fill accounting and a pipelined read port
//--------------------------------------------------
module frame_ring_ram (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_wr_en,
    input  cpri_buf_pkg::frame_addr_t i_wr_addr,
    input  cpri_buf_pkg::data_word_t  i_wr_data,
    input  logic                      i_wr_frame_end,
    input  logic                      i_rd_en,
    input  cpri_buf_pkg::frame_addr_t i_rd_addr,
    input  logic                      i_rd_frame_end,
    output cpri_buf_pkg::data_word_t  o_rd_data,
    output logic                      o_rd_valid,
    output logic                      o_frame_ready,
    output cpri_buf_pkg::slot_cnt_t   o_fill
);
    import cpri_buf_pkg::*;

    data_word_t                   mem [NUM_SLOTS][FRAME_WORDS];
    logic [$clog2(NUM_SLOTS)-1:0] wr_slot;
    logic [$clog2(NUM_SLOTS)-1:0] rd_slot;
    slot_cnt_t                    fill;
    logic                         commit;
    logic                         retire;
    data_word_t                   rd_pipe [RAM_READ_LATENCY];
    logic [RAM_READ_LATENCY-1:0]  vld_pipe;

    // Slot handover happens on the last word of a frame
    assign commit = i_wr_en & i_wr_frame_end;
    assign retire = i_rd_en & i_rd_frame_end;

    //--------------------------------------------------
    // Memory array
    //--------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[wr_slot][i_wr_addr] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clk) begin
        rd_pipe[0] <= mem[rd_slot][i_rd_addr];
        for (int i = 1; i < RAM_READ_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= (vld_pipe << 1) | RAM_READ_LATENCY'(i_rd_en);
        end
    end

    //--------------------------------------------------
    // Slot pointers and fill count
    //--------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_slot <= '0;
            rd_slot <= '0;
            fill    <= '0;
        end else begin
            if (commit) begin
                wr_slot <= (wr_slot == NUM_SLOTS - 1) ? '0 : wr_slot + 1'b1;
            end
            if (retire) begin
                rd_slot <= (rd_slot == NUM_SLOTS - 1) ? '0 : rd_slot + 1'b1;
            end
            fill <= fill + slot_cnt_t'(commit) - slot_cnt_t'(retire);
        end
    end

    assign o_rd_data     = rd_pipe[RAM_READ_LATENCY-1];
    assign o_rd_valid    = vld_pipe[RAM_READ_LATENCY-1];
    assign o_frame_ready = (fill != '0);
    assign o_fill        = fill;

    // Writer must have taken a free slot at its frame start
    a_no_write_when_full: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wr_en |-> fill != slot_cnt_t'(NUM_SLOTS))
        else $error("write into a full frame memory");

    // Reader must only run on a committed frame
    a_no_read_when_empty: assert property (@(posedge i_clk) disable iff (i_reset)
        i_rd_en |-> fill != '0)
        else $error("read from an empty frame memory");

endmodule

/* rtl/cpri_buf_pkg.sv */
//--------------------------------------------------
// CPRI receive buffer shared definitions
// Frame geometry, data types and register map
//--------------------------------------------------
package cpri_buf_pkg;

    // Frame geometry
    localparam int FRAME_WORDS      = 192;
    localparam int CHIP_WORDS       = 96;
    localparam int NUM_SLOTS        = 2;
    localparam int RAM_READ_LATENCY = 2;

    typedef logic [63:0] data_word_t;
    typedef logic [7:0]  frame_addr_t;
    typedef logic [6:0]  chip_seq_t;
    typedef logic [1:0]  slot_cnt_t;

    //--------------------------------------------------
    // AXI4-Lite register map
    //--------------------------------------------------
    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;

    localparam logic [AXI_ADDR_W-1:0] REG_CTRL       = 8'h00;
    localparam logic [AXI_ADDR_W-1:0] REG_FRAMES_IN  = 8'h04;
    localparam logic [AXI_ADDR_W-1:0] REG_FRAMES_OUT = 8'h08;
    localparam logic [AXI_ADDR_W-1:0] REG_DROPPED    = 8'h0C;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS     = 8'h10;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        CSR_IDLE,
        CSR_WRESP,
        CSR_RRESP
    } csr_state_t;

endpackage
